/* verilog/vpu_config.svh */
`ifndef VPU_CONFIG_SVH
`define VPU_CONFIG_SVH

// SRAM word and operand address
`define VPU_DATA_WIDTH      32
`define VPU_ADDR_WIDTH      6

// Bank split, low address bits pick the bank
`define VPU_BANK_CNT_LG2    1
`define VPU_BANK_DEPTH_LG2  (`VPU_ADDR_WIDTH - `VPU_BANK_CNT_LG2)

// Operand queue and vector length
`define VPU_QUEUE_DEPTH     4
`define VPU_LEN_WIDTH       3
`define VPU_MAX_LEN         4

`endif

/* verilog/vpu_pkg.sv */
`include "vpu_config.svh"

package vpu_pkg;

    typedef enum logic [1:0] {
        ADD = 2'd0,
        SUB = 2'd1,
        MAX = 2'd2
    } vpu_opcode_e;

    // One vector command
    typedef struct packed {
        vpu_opcode_e                    opcode;
        logic                           elem16;
        logic [`VPU_ADDR_WIDTH-1:0]     src0_addr;
        logic [`VPU_ADDR_WIDTH-1:0]     src1_addr;
        logic [`VPU_LEN_WIDTH-1:0]      len;
    } vpu_op_t;

    // Data word as 8-bit or 16-bit lanes
    typedef union packed {
        logic [`VPU_DATA_WIDTH/8-1:0][7:0]      lane8;
        logic [`VPU_DATA_WIDTH/16-1:0][15:0]    lane16;
    } vpu_word_u;

    typedef struct packed {
        logic                               req;
        logic [`VPU_BANK_CNT_LG2-1:0]       rid;
        logic [`VPU_BANK_DEPTH_LG2-1:0]     addr;
        logic                               reb;
        logic                               rlast;
    } sram_rd_req_t;

    typedef struct packed {
        logic                           ack;
        logic                           rvalid;
        logic [`VPU_DATA_WIDTH-1:0]     rdata;
    } sram_rd_rsp_t;

    function automatic logic [`VPU_BANK_CNT_LG2-1:0] get_bank_id(
        input logic [`VPU_ADDR_WIDTH-1:0] addr
    );
        return addr[`VPU_BANK_CNT_LG2-1:0];
    endfunction

    function automatic logic [`VPU_BANK_DEPTH_LG2-1:0] get_bank_addr(
        input logic [`VPU_ADDR_WIDTH-1:0] addr
    );
        return addr[`VPU_ADDR_WIDTH-1:`VPU_BANK_CNT_LG2];
    endfunction

endpackage

/* verilog/vpu_operand_sram.sv */
`timescale 1ns/1ps
`include "vpu_config.svh"

module vpu_operand_sram (
    input  logic                            clk,
    input  logic                            rst_n,
    input  vpu_pkg::sram_rd_req_t           rd_req0_i,
    input  vpu_pkg::sram_rd_req_t           rd_req1_i,
    input  logic                            wr_en_i,
    input  logic [`VPU_ADDR_WIDTH-1:0]      wr_addr_i,
    input  logic [`VPU_DATA_WIDTH-1:0]      wr_data_i,
    output vpu_pkg::sram_rd_rsp_t           rd_rsp0_o,
    output vpu_pkg::sram_rd_rsp_t           rd_rsp1_o
);
    import vpu_pkg::*;

    localparam int BANK_CNT   = 1 << `VPU_BANK_CNT_LG2;
    localparam int BANK_DEPTH = 1 << `VPU_BANK_DEPTH_LG2;

    logic [`VPU_DATA_WIDTH-1:0]     bank_mem [BANK_CNT][BANK_DEPTH];

    logic                           gnt0;
    logic                           gnt1;
    logic                           rvalid0_q;
    logic                           rvalid1_q;
    logic [`VPU_DATA_WIDTH-1:0]     rdata0_q;
    logic [`VPU_DATA_WIDTH-1:0]     rdata1_q;

    // Port 0 always wins its bank
    assign gnt0 = rd_req0_i.req && !rd_req0_i.reb;

    // Port 1 waits when both hit the same bank
    assign gnt1 = rd_req1_i.req && !rd_req1_i.reb &&
                  !(gnt0 && (rd_req0_i.rid == rd_req1_i.rid));

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            bank_mem[get_bank_id(wr_addr_i)][get_bank_addr(wr_addr_i)] <= wr_data_i;
        end
        if (gnt0) begin
            rdata0_q <= bank_mem[rd_req0_i.rid][rd_req0_i.addr];
        end
        if (gnt1) begin
            rdata1_q <= bank_mem[rd_req1_i.rid][rd_req1_i.addr];
        end
    end

    // Read data returns one cycle after the grant
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid0_q <= 1'b0;
            rvalid1_q <= 1'b0;
        end else begin
            rvalid0_q <= gnt0;
            rvalid1_q <= gnt1;
        end
    end

    assign rd_rsp0_o = '{ack: gnt0, rvalid: rvalid0_q, rdata: rdata0_q};
    assign rd_rsp1_o = '{ack: gnt1, rvalid: rvalid1_q, rdata: rdata1_q};

endmodule

/* verilog/vpu_src_port_controller.sv */
`timescale 1ns/1ps
`include "vpu_config.svh"

module vpu_src_port_controller (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            start_i,
    input  logic [`VPU_ADDR_WIDTH-1:0]      raddr_i,
    input  logic [`VPU_LEN_WIDTH-1:0]       len_i,
    input  vpu_pkg::sram_rd_rsp_t           sram_rsp_i,
    output logic                            done_o,
    output vpu_pkg::sram_rd_req_t           sram_req_o,
    output logic [`VPU_DATA_WIDTH-1:0]      operand_fifo_wdata_o,
    output logic                            operand_fifo_wren_o
);
    import vpu_pkg::*;

    typedef enum logic {
        S_IDLE,
        S_READ
    } state_e;

    localparam sram_rd_req_t REQ_IDLE = '{req: 1'b0, rid: '0, addr: '0, reb: 1'b1, rlast: 1'b0};

    state_e                         state;
    sram_rd_req_t                   req_q;
    logic [`VPU_ADDR_WIDTH-1:0]     next_addr;
    // Words left to request after the one on the bus
    logic [`VPU_LEN_WIDTH-1:0]      issue_left;
    // Words requested or not yet returned
    logic [`VPU_LEN_WIDTH-1:0]      pend_cnt;
    logic                           ret_fire;

    assign ret_fire = (state == S_READ) && sram_rsp_i.rvalid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            req_q      <= REQ_IDLE;
            next_addr  <= '0;
            issue_left <= '0;
            pend_cnt   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start_i) begin
                        state       <= S_READ;
                        req_q.req   <= 1'b1;
                        req_q.rid   <= get_bank_id(raddr_i);
                        req_q.addr  <= get_bank_addr(raddr_i);
                        req_q.reb   <= 1'b0;
                        req_q.rlast <= (len_i == `VPU_LEN_WIDTH'(1));
                        next_addr   <= raddr_i + 1'b1;
                        issue_left  <= len_i - 1'b1;
                        pend_cnt    <= len_i;
                    end
                end

                S_READ: begin
                    // Next address goes out right after an ack
                    if (req_q.req && sram_rsp_i.ack) begin
                        if (issue_left != '0) begin
                            req_q.rid   <= get_bank_id(next_addr);
                            req_q.addr  <= get_bank_addr(next_addr);
                            req_q.rlast <= (issue_left == `VPU_LEN_WIDTH'(1));
                            next_addr   <= next_addr + 1'b1;
                            issue_left  <= issue_left - 1'b1;
                        end else begin
                            req_q <= REQ_IDLE;
                        end
                    end
                    if (ret_fire) begin
                        pend_cnt <= pend_cnt - 1'b1;
                        if (pend_cnt == `VPU_LEN_WIDTH'(1)) begin
                            state <= S_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    assign sram_req_o           = req_q;
    assign operand_fifo_wdata_o = sram_rsp_i.rdata;
    assign operand_fifo_wren_o  = ret_fire;
    assign done_o               = (state == S_IDLE);

endmodule

/* verilog/vpu_operand_queue.sv */
`timescale 1ns/1ps
`include "vpu_config.svh"

module vpu_operand_queue (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            wren_i,
    input  logic [`VPU_DATA_WIDTH-1:0]      wdata_i,
    input  logic                            rden_i,
    output logic [`VPU_DATA_WIDTH-1:0]      rdata_o,
    output logic                            empty_o
);

    localparam int PTR_W = $clog2(`VPU_QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`VPU_QUEUE_DEPTH + 1);

    logic [`VPU_DATA_WIDTH-1:0]     mem [`VPU_QUEUE_DEPTH];
    logic [PTR_W-1:0]               wr_ptr;
    logic [PTR_W-1:0]               rd_ptr;
    logic [CNT_W-1:0]               count;
    logic                           do_wr;
    logic                           do_rd;

    assign do_rd = rden_i && !empty_o;
    assign do_wr = wren_i && (count != CNT_W'(`VPU_QUEUE_DEPTH));

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdata_i;
        end
    end

    // Depth is a power of two, pointers wrap on their own
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_wr) - CNT_W'(do_rd);
        end
    end

    assign rdata_o = mem[rd_ptr];
    assign empty_o = (count == '0);

endmodule

/* verilog/vpu_lane_alu.sv */
`timescale 1ns/1ps
`include "vpu_config.svh"

module vpu_lane_alu (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    valid_i,
    input  vpu_pkg::vpu_opcode_e    opcode_i,
    input  logic                    elem16_i,
    input  vpu_pkg::vpu_word_u      a_i,
    input  vpu_pkg::vpu_word_u      b_i,
    output logic                    valid_o,
    output vpu_pkg::vpu_word_u      result_o
);
    import vpu_pkg::*;

    localparam int LANES8  = `VPU_DATA_WIDTH / 8;
    localparam int LANES16 = `VPU_DATA_WIDTH / 16;

    vpu_word_u  res;

    // Lanes are independent, carries never cross a lane
    always_comb begin
        res = '0;
        if (elem16_i) begin
            for (int i = 0; i < LANES16; i++) begin
                case (opcode_i)
                    ADD:     res.lane16[i] = a_i.lane16[i] + b_i.lane16[i];
                    SUB:     res.lane16[i] = a_i.lane16[i] - b_i.lane16[i];
                    MAX:     res.lane16[i] = (a_i.lane16[i] > b_i.lane16[i]) ?
                                             a_i.lane16[i] : b_i.lane16[i];
                    default: res.lane16[i] = a_i.lane16[i];
                endcase
            end
        end else begin
            for (int i = 0; i < LANES8; i++) begin
                case (opcode_i)
                    ADD:     res.lane8[i] = a_i.lane8[i] + b_i.lane8[i];
                    SUB:     res.lane8[i] = a_i.lane8[i] - b_i.lane8[i];
                    MAX:     res.lane8[i] = (a_i.lane8[i] > b_i.lane8[i]) ?
                                            a_i.lane8[i] : b_i.lane8[i];
                    default: res.lane8[i] = a_i.lane8[i];
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        result_o <= res;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

endmodule

/* verilog/vpu_controller.sv */
`timescale 1ns/1ps
`include "vpu_config.svh"

module vpu_controller (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_i,
    input  vpu_pkg::vpu_op_t    op_i,
    input  logic                port0_done_i,
    input  logic                port1_done_i,
    input  logic                q0_empty_i,
    input  logic                q1_empty_i,
    output logic                port_start_o,
    output vpu_pkg::vpu_op_t    op_o,
    output logic                pop_o,
    output logic                done_o
);
    import vpu_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_DRAIN
    } state_e;

    state_e                         state;
    vpu_op_t                        op_q;
    logic [`VPU_LEN_WIDTH-1:0]      pop_cnt;
    logic                           accept;
    logic                           last_pop;

    // Strobes while busy are dropped here
    assign accept   = (state == S_IDLE) && start_i;
    assign pop_o    = (state == S_RUN) && !q0_empty_i && !q1_empty_i;
    assign last_pop = pop_o && (pop_cnt == op_q.len - `VPU_LEN_WIDTH'(1));

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q <= op_i;
            if (op_i.len > `VPU_LEN_WIDTH'(`VPU_MAX_LEN)) begin
                op_q.len <= `VPU_LEN_WIDTH'(`VPU_MAX_LEN);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= S_IDLE;
            pop_cnt      <= '0;
            port_start_o <= 1'b0;
        end else begin
            port_start_o <= accept;
            case (state)
                S_IDLE: begin
                    pop_cnt <= '0;
                    if (accept) begin
                        state <= S_RUN;
                    end
                end
                S_RUN: begin
                    if (pop_o) begin
                        pop_cnt <= pop_cnt + 1'b1;
                    end
                    if (last_pop) begin
                        state <= S_DRAIN;
                    end
                end
                // Last ALU result is on the output this cycle
                S_DRAIN: begin
                    if (port0_done_i && port1_done_i) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign op_o   = op_q;
    assign done_o = (state == S_IDLE);

endmodule

/* verilog/vpu_top.sv */
`timescale 1ns/1ps
`include "vpu_config.svh"

module vpu_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            start_i,
    input  vpu_pkg::vpu_op_t                op_i,
    input  logic                            wr_en_i,
    input  logic [`VPU_ADDR_WIDTH-1:0]      wr_addr_i,
    input  logic [`VPU_DATA_WIDTH-1:0]      wr_data_i,
    output logic                            done_o,
    output logic                            result_valid_o,
    output vpu_pkg::vpu_word_u              result_o
);
    import vpu_pkg::*;

    vpu_op_t                        op_q;
    logic                           port_start;
    logic                           pop;
    logic                           port0_done;
    logic                           port1_done;
    sram_rd_req_t                   rd_req0;
    sram_rd_req_t                   rd_req1;
    sram_rd_rsp_t                   rd_rsp0;
    sram_rd_rsp_t                   rd_rsp1;
    logic                           q0_wren;
    logic                           q1_wren;
    logic                           q0_empty;
    logic                           q1_empty;
    logic [`VPU_DATA_WIDTH-1:0]     q0_wdata;
    logic [`VPU_DATA_WIDTH-1:0]     q1_wdata;
    logic [`VPU_DATA_WIDTH-1:0]     q0_rdata;
    logic [`VPU_DATA_WIDTH-1:0]     q1_rdata;

    vpu_controller u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .op_i         (op_i),
        .port0_done_i (port0_done),
        .port1_done_i (port1_done),
        .q0_empty_i   (q0_empty),
        .q1_empty_i   (q1_empty),
        .port_start_o (port_start),
        .op_o         (op_q),
        .pop_o        (pop),
        .done_o       (done_o)
    );

    // Source 0 has bank priority in the SRAM
    vpu_src_port_controller u_port0 (
        .clk                  (clk),
        .rst_n                (rst_n),
        .start_i              (port_start),
        .raddr_i              (op_q.src0_addr),
        .len_i                (op_q.len),
        .sram_rsp_i           (rd_rsp0),
        .done_o               (port0_done),
        .sram_req_o           (rd_req0),
        .operand_fifo_wdata_o (q0_wdata),
        .operand_fifo_wren_o  (q0_wren)
    );

    vpu_src_port_controller u_port1 (
        .clk                  (clk),
        .rst_n                (rst_n),
        .start_i              (port_start),
        .raddr_i              (op_q.src1_addr),
        .len_i                (op_q.len),
        .sram_rsp_i           (rd_rsp1),
        .done_o               (port1_done),
        .sram_req_o           (rd_req1),
        .operand_fifo_wdata_o (q1_wdata),
        .operand_fifo_wren_o  (q1_wren)
    );

    vpu_operand_queue u_queue0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .wren_i  (q0_wren),
        .wdata_i (q0_wdata),
        .rden_i  (pop),
        .rdata_o (q0_rdata),
        .empty_o (q0_empty)
    );

    vpu_operand_queue u_queue1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .wren_i  (q1_wren),
        .wdata_i (q1_wdata),
        .rden_i  (pop),
        .rdata_o (q1_rdata),
        .empty_o (q1_empty)
    );

    vpu_operand_sram u_sram (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_req0_i (rd_req0),
        .rd_req1_i (rd_req1),
        .wr_en_i   (wr_en_i),
        .wr_addr_i (wr_addr_i),
        .wr_data_i (wr_data_i),
        .rd_rsp0_o (rd_rsp0),
        .rd_rsp1_o (rd_rsp1)
    );

    // Head pair goes in on the pop, result one cycle later
    vpu_lane_alu u_alu (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid_i  (pop),
        .opcode_i (op_q.opcode),
        .elem16_i (op_q.elem16),
        .a_i      (q0_rdata),
        .b_i      (q1_rdata),
        .valid_o  (result_valid_o),
        .result_o (result_o)
    );

endmodule

/* testbench/vpu_clock_gen.sv */
`timescale 1ns/1ps

module vpu_clock_gen (
    output logic clk_o
);

    // 10 ns period
    initial begin
        clk_o = 1'b0;
    end

    always begin
        #5 clk_o = ~clk_o;
    end

endmodule

/* testbench/vpu_properties.sv */
`timescale 1ns/1ps

module vpu_properties (
    input logic                     clk,
    input logic                     rst_n,
    input vpu_pkg::sram_rd_req_t    req0_i,
    input vpu_pkg::sram_rd_req_t    req1_i,
    input vpu_pkg::sram_rd_rsp_t    rsp0_i,
    input vpu_pkg::sram_rd_rsp_t    rsp1_i
);

    // Grant only for a live request
    ack0_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        rsp0_i.ack |-> req0_i.req)
        else $error("port 0 ack without req");

    ack1_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        rsp1_i.ack |-> req1_i.req)
        else $error("port 1 ack without req");

    // Data returns exactly one cycle after the grant
    ack0_then_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
        rsp0_i.ack |=> rsp0_i.rvalid)
        else $error("port 0 rvalid missing after ack");

    ack1_then_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
        rsp1_i.ack |=> rsp1_i.rvalid)
        else $error("port 1 rvalid missing after ack");

    rvalid0_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        rsp0_i.rvalid |-> $past(rsp0_i.ack))
        else $error("port 0 rvalid without earlier ack");

    rvalid1_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        rsp1_i.rvalid |-> $past(rsp1_i.ack))
        else $error("port 1 rvalid without earlier ack");

endmodule

bind vpu_operand_sram vpu_properties u_props (
    .clk    (clk),
    .rst_n  (rst_n),
    .req0_i (rd_req0_i),
    .req1_i (rd_req1_i),
    .rsp0_i (rd_rsp0_o),
    .rsp1_i (rd_rsp1_o)
);

/* testbench/vpu_tb.sv */
`timescale 1ns/1ps
`include "vpu_config.svh"

module vpu_tb;
    import vpu_pkg::*;

    // About 32 commands of up to 40 cycles, two full preloads and reset, with margin
    localparam int TIMEOUT_CYCLES = 3000;
    localparam int CMD_WAIT_LIMIT = 40;
    localparam int MEM_WORDS      = 1 << `VPU_ADDR_WIDTH;

    logic                           clk;
    logic                           rst_n;
    logic                           start_i;
    vpu_op_t                        op_i;
    logic                           wr_en_i;
    logic [`VPU_ADDR_WIDTH-1:0]     wr_addr_i;
    logic [`VPU_DATA_WIDTH-1:0]     wr_data_i;
    logic                           done_o;
    logic                           result_valid_o;
    vpu_word_u                      result_o;

    logic [`VPU_DATA_WIDTH-1:0]     mem_model [MEM_WORDS];
    logic [`VPU_DATA_WIDTH-1:0]     result_q [$];
    int                             err_cnt;
    int                             chk_cnt;
    int                             cycle_cnt;

    vpu_clock_gen u_clk (
        .clk_o (clk)
    );

    vpu_top DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (start_i),
        .op_i           (op_i),
        .wr_en_i        (wr_en_i),
        .wr_addr_i      (wr_addr_i),
        .wr_data_i      (wr_data_i),
        .done_o         (done_o),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

    // Result monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && result_valid_o) begin
            result_q.push_back(result_o);
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycle_cnt);
            $display("checks: %0d  errors: %0d", chk_cnt, err_cnt + 1);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // Lane rule: wraparound add and subtract, unsigned max, no carry between lanes
    function automatic logic [`VPU_DATA_WIDTH-1:0] lane_result(
        input vpu_opcode_e                  opc,
        input logic                         e16,
        input logic [`VPU_DATA_WIDTH-1:0]   a,
        input logic [`VPU_DATA_WIDTH-1:0]   b
    );
        logic [`VPU_DATA_WIDTH-1:0] r;
        int                         w;
        logic [15:0]                x;
        logic [15:0]                y;
        logic [15:0]                z;
        logic [15:0]                mask;
        r    = '0;
        w    = e16 ? 16 : 8;
        mask = e16 ? 16'hFFFF : 16'h00FF;
        for (int i = 0; i < `VPU_DATA_WIDTH / w; i++) begin
            x = 16'((a >> (i * w))) & mask;
            y = 16'((b >> (i * w))) & mask;
            case (opc)
                ADD:     z = (x + y) & mask;
                SUB:     z = (x - y) & mask;
                MAX:     z = (x > y) ? x : y;
                default: z = x;
            endcase
            r = r | (`VPU_DATA_WIDTH'(z) << (i * w));
        end
        return r;
    endfunction

    function automatic logic [`VPU_ADDR_WIDTH-1:0] addr_at(
        input logic [`VPU_ADDR_WIDTH-1:0]   base,
        input int                           idx
    );
        return `VPU_ADDR_WIDTH'(int'(base) + idx);
    endfunction

    function automatic vpu_op_t make_op(
        input vpu_opcode_e                  opc,
        input logic                         e16,
        input logic [`VPU_ADDR_WIDTH-1:0]   s0,
        input logic [`VPU_ADDR_WIDTH-1:0]   s1,
        input logic [`VPU_LEN_WIDTH-1:0]    len
    );
        vpu_op_t op;
        op.opcode    = opc;
        op.elem16    = e16;
        op.src0_addr = s0;
        op.src1_addr = s1;
        op.len       = len;
        return op;
    endfunction

    task automatic write_word(
        input logic [`VPU_ADDR_WIDTH-1:0]   addr,
        input logic [`VPU_DATA_WIDTH-1:0]   data
    );
        wr_en_i   = 1'b1;
        wr_addr_i = addr;
        wr_data_i = data;
        mem_model[addr] = data;
        @(negedge clk);
        wr_en_i = 1'b0;
    endtask

    task automatic preload_pattern();
        logic [`VPU_ADDR_WIDTH-1:0] a;
        for (int i = 0; i < MEM_WORDS; i++) begin
            a = `VPU_ADDR_WIDTH'(i);
            write_word(a, {a, 2'b10, ~a, 2'b01, a ^ 6'h2A, 2'b11, a, 2'b00});
        end
    endtask

    task automatic preload_random();
        for (int i = 0; i < MEM_WORDS; i++) begin
            write_word(`VPU_ADDR_WIDTH'(i), $urandom);
        end
    endtask

    task automatic send_start(input vpu_op_t op);
        start_i = 1'b1;
        op_i    = op;
        @(negedge clk);
        start_i = 1'b0;
    endtask

    // Wait for done, then compare collected results in vector order
    task automatic finish_cmd(input vpu_op_t op);
        int                         waited;
        logic [`VPU_DATA_WIDTH-1:0] exp;
        waited = 0;
        while (done_o !== 1'b1 && waited < CMD_WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        chk_cnt++;
        if (done_o !== 1'b1) begin
            err_cnt++;
            $display("done_o did not return high within %0d cycles", CMD_WAIT_LIMIT);
        end
        chk_cnt++;
        if (result_q.size() != int'(op.len)) begin
            err_cnt++;
            $display("error: result_valid_o pulse count got %h expected %h",
                     result_q.size(), op.len);
        end
        for (int i = 0; i < int'(op.len) && i < result_q.size(); i++) begin
            exp = lane_result(op.opcode, op.elem16,
                              mem_model[addr_at(op.src0_addr, i)],
                              mem_model[addr_at(op.src1_addr, i)]);
            chk_cnt++;
            if (result_q[i] !== exp) begin
                err_cnt++;
                $display("error: result_o word %0d got %h expected %h", i, result_q[i], exp);
            end
        end
    endtask

    task automatic run_cmd(input vpu_op_t op);
        result_q.delete();
        send_start(op);
        finish_cmd(op);
    endtask

    task automatic reset_and_add_8bit();
        chk_cnt++;
        if (done_o !== 1'b1 || result_valid_o !== 1'b0) begin
            err_cnt++;
            $display("error: after reset done_o %h result_valid_o %h expected 1 and 0",
                     done_o, result_valid_o);
        end
        write_word(6'd2, 32'hF0807F01);
        write_word(6'd7, 32'h208001FF);
        run_cmd(make_op(ADD, 1'b0, 6'd2, 6'd7, 3'd1));
    endtask

    task automatic wide_lane_sub_max();
        write_word(6'd12, 32'h00058000);
        write_word(6'd45, 32'h00108001);
        write_word(6'd14, 32'h80FF0100);
        write_word(6'd47, 32'h7F0000FF);
        run_cmd(make_op(SUB, 1'b1, 6'd12, 6'd45, 3'd1));
        run_cmd(make_op(SUB, 1'b0, 6'd12, 6'd45, 3'd1));
        run_cmd(make_op(MAX, 1'b1, 6'd14, 6'd47, 3'd1));
        run_cmd(make_op(MAX, 1'b0, 6'd14, 6'd47, 3'd1));
    endtask

    // Both sources start in the same bank, so port 1 loses the first grant
    task automatic same_bank_runs();
        run_cmd(make_op(ADD, 1'b0, 6'd8, 6'd40, 3'd4));
        run_cmd(make_op(MAX, 1'b1, 6'd3, 6'd33, 3'd4));
        run_cmd(make_op(SUB, 1'b0, 6'd62, 6'd30, 3'd4));
    endtask

    task automatic split_bank_runs();
        run_cmd(make_op(ADD, 1'b1, 6'd8, 6'd17, 3'd4));
        run_cmd(make_op(SUB, 1'b0, 6'd21, 6'd50, 3'd4));
        run_cmd(make_op(MAX, 1'b0, 6'd5, 6'd34, 3'd4));
    endtask

    task automatic busy_start_ignored();
        vpu_op_t op_a;
        vpu_op_t op_b;
        op_a = make_op(ADD, 1'b0, 6'd16, 6'd33, 3'd4);
        op_b = make_op(SUB, 1'b1, 6'd40, 6'd41, 3'd2);
        result_q.delete();
        send_start(op_a);
        chk_cnt++;
        if (done_o !== 1'b0) begin
            err_cnt++;
            $display("error: done_o after an accepted start got %h expected 0", done_o);
        end
        send_start(op_b);
        send_start(op_b);
        finish_cmd(op_a);
        repeat (8) @(negedge clk);
        chk_cnt++;
        if (result_q.size() != int'(op_a.len) || done_o !== 1'b1) begin
            err_cnt++;
            $display("error: after ignored start result count %h done_o %h expected %h and 1",
                     result_q.size(), done_o, op_a.len);
        end
    endtask

    task automatic random_cmd_runs();
        vpu_op_t op;
        preload_random();
        for (int n = 0; n < 20; n++) begin
            op = make_op(vpu_opcode_e'($urandom_range(0, 2)), 1'($urandom),
                         `VPU_ADDR_WIDTH'($urandom), `VPU_ADDR_WIDTH'($urandom),
                         `VPU_LEN_WIDTH'($urandom_range(1, `VPU_MAX_LEN)));
            run_cmd(op);
        end
    endtask

    initial begin
        void'($urandom(26776));
        err_cnt   = 0;
        chk_cnt   = 0;
        cycle_cnt = 0;
        rst_n     = 1'b0;
        start_i   = 1'b0;
        op_i      = '0;
        wr_en_i   = 1'b0;
        wr_addr_i = '0;
        wr_data_i = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        preload_pattern();
        reset_and_add_8bit();
        wide_lane_sub_max();
        same_bank_runs();
        split_bank_runs();
        busy_start_ignored();
        random_cmd_runs();

        $display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+verilog
verilog/vpu_pkg.sv
verilog/vpu_operand_sram.sv
verilog/vpu_src_port_controller.sv
verilog/vpu_operand_queue.sv
verilog/vpu_lane_alu.sv
verilog/vpu_controller.sv
verilog/vpu_top.sv
testbench/vpu_clock_gen.sv
testbench/vpu_properties.sv
testbench/vpu_tb.sv

/* run.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module vpu_tb -o vpu_sim

./obj_dir/vpu_sim | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
